// File: Makefile
VERILATOR ?= verilator
TOP ?= adc_frame_tb
FILELIST ?= adc_frame.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VERILATOR_FLAGS RUN_ARGS PASS_MSG"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: adc_frame.f
+incdir+verilog
verilog/stream_pkg.sv
verilog/frame_format_pkg.sv
verilog/beat_decoder.sv
verilog/frame_assembler.sv
verilog/frame_fifo.sv
verilog/frame_serializer.sv
verilog/adc_frame_top.sv
tests/adc_frame_properties.sv
tests/adc_frame_tb.sv

// File: tests/adc_frame_properties.sv
`timescale 1ns/1ps
`include "adc_frame_macros.svh"

module adc_frame_properties (
  input logic                    WR_CLK,
  input logic                    WR_RESET,
  input logic                    out_valid,
  input logic [`WORD_WIDTH-1:0]  out_data,
  input logic                    out_last,
  input logic                    out_ready,
  input logic                    data_wr_valid,
  input logic                    data_wr_ready,
  input logic                    data_rd_valid,
  input logic                    data_rd_ready,
  input logic                    info_wr_valid,
  input logic                    info_wr_ready,
  input logic                    info_rd_valid,
  input logic                    info_rd_ready
);

  int unsigned fail_count = 0;
  int          data_occ;
  int          info_occ;

  // shadow occupancy of both FIFOs
  always_ff @(posedge WR_CLK) begin
    if (WR_RESET) begin
      data_occ <= 0;
      info_occ <= 0;
    end else begin
      data_occ <= data_occ + int'(data_wr_valid && data_wr_ready)
                  - int'(data_rd_valid && data_rd_ready);
      info_occ <= info_occ + int'(info_wr_valid && info_wr_ready)
                  - int'(info_rd_valid && info_rd_ready);
    end
  end

  stall_holds: assert property (@(posedge WR_CLK) disable iff (WR_RESET)
    out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
  else begin
    fail_count++;
    $error("out_data or out_last changed while stalled");
  end

  reset_quiet: assert property (@(posedge WR_CLK) WR_RESET |=> !out_valid)
  else begin
    fail_count++;
    $error("out_valid high during or right after reset");
  end

  data_not_full: assert property (@(posedge WR_CLK) disable iff (WR_RESET)
    data_wr_valid && data_wr_ready |-> data_occ < `DATA_FIFO_DEPTH)
  else begin
    fail_count++;
    $error("write into a full data FIFO");
  end

  info_not_full: assert property (@(posedge WR_CLK) disable iff (WR_RESET)
    info_wr_valid && info_wr_ready |-> info_occ < `INFO_FIFO_DEPTH)
  else begin
    fail_count++;
    $error("write into a full info FIFO");
  end

  last_has_valid: assert property (@(posedge WR_CLK) disable iff (WR_RESET)
    out_last |-> out_valid)
  else begin
    fail_count++;
    $error("out_last high without out_valid");
  end

endmodule

bind adc_frame_top adc_frame_properties props0 (
  .WR_CLK        (WR_CLK),
  .WR_RESET      (WR_RESET),
  .out_valid     (out_valid),
  .out_data      (out_data),
  .out_last      (out_last),
  .out_ready     (out_ready),
  .data_wr_valid (data_wr_valid),
  .data_wr_ready (data_wr_ready),
  .data_rd_valid (data_rd_valid),
  .data_rd_ready (data_rd_ready),
  .info_wr_valid (info_wr_valid),
  .info_wr_ready (info_wr_ready),
  .info_rd_valid (info_rd_valid),
  .info_rd_ready (info_rd_ready)
);

// File: tests/adc_frame_tb.sv
`timescale 1ns/1ps
`include "adc_frame_macros.svh"

module adc_frame_tb;

  localparam int CHANNEL = 5;
  localparam logic [`HOLD_WIDTH-1:0] HOLD = 3;
  localparam int PAT_LEN = 1024;

  logic                    WR_CLK;
  logic                    WR_RESET;
  logic [`HOLD_WIDTH-1:0]  hold_len;
  logic                    in_valid;
  stream_pkg::in_beat_t    in_beat;
  logic                    in_ready;
  logic                    out_valid;
  logic [`WORD_WIDTH-1:0]  out_data;
  logic                    out_last;
  logic                    out_ready;

  integer                  seed;
  int                      errors;
  int                      tests_ok;
  int                      tests_bad;
  int                      words_seen;
  int                      frames_seen;
  int                      frames_expected;
  int                      idle_count;
  bit                      model_open;
  bit                      stall_seen;
  logic [1:0]              ready_mode;
  int                      ready_idx;
  bit                      ready_pat [PAT_LEN];
  logic [`WORD_WIDTH-1:0]  exp_words [$];
  bit                      exp_last [$];
  stream_pkg::in_beat_t    frame_beats [$];

  adc_frame_top #(
    .CHANNEL_ID (CHANNEL)
  ) dut0 (
    .WR_CLK    (WR_CLK),
    .WR_RESET  (WR_RESET),
    .hold_len  (hold_len),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

  always #50 WR_CLK = ~WR_CLK;

  function automatic logic [`WORD_WIDTH-1:0] header_word(stream_pkg::in_beat_t first, int beats);
    return {`HEADER_ID, 4'(CHANNEL), first.stamp[23:0], 12'h000, 16'(2 * beats)};
  endfunction

  // one-bit fills and the upper stamp of the last beat
  function automatic logic [`WORD_WIDTH-1:0] footer_word(stream_pkg::in_beat_t last);
    return {4'hF, last.baseline, 3'h7, last.threshold, last.stamp[47:24], `FOOTER_ID};
  endfunction

  function automatic stream_pkg::in_beat_t make_beat();
    stream_pkg::in_beat_t b;
    b.sample = {$random(seed), $random(seed), $random(seed), $random(seed)};
    b.stamp = 48'({$random(seed), $random(seed)});
    b.baseline = 12'($random(seed));
    b.threshold = 13'($random(seed));
    return b;
  endfunction

  function automatic void close_model_frame();
    int n;
    int k;
    n = frame_beats.size();
    exp_words.push_back(header_word(frame_beats[0], n));
    exp_last.push_back(1'b0);
    for (k = 0; k < n; k++) begin
      exp_words.push_back(frame_beats[k].sample[127:64]);
      exp_last.push_back(1'b0);
      exp_words.push_back(frame_beats[k].sample[63:0]);
      exp_last.push_back(1'b0);
    end
    exp_words.push_back(footer_word(frame_beats[n-1]));
    exp_last.push_back(1'b1);
    frame_beats.delete();
    model_open = 1'b0;
    frames_expected++;
  endfunction

  // reference model fed by input transfers
  always @(posedge WR_CLK) begin
    if (!WR_RESET) begin
      if (in_valid && !in_ready) begin
        stall_seen = 1'b1;
      end
      if (in_valid && in_ready) begin
        idle_count = 0;
        model_open = 1'b1;
        frame_beats.push_back(in_beat);
        if (frame_beats.size() == `MAX_FRAME_BEATS) begin
          close_model_frame();
        end
      end else if (model_open) begin
        idle_count++;
        if (idle_count > HOLD) begin
          close_model_frame();
        end
      end
    end
  end

  // output word check
  always @(posedge WR_CLK) begin
    logic [`WORD_WIDTH-1:0] w;
    bit                     l;
    if (!WR_RESET && out_valid && out_ready) begin
      assert (exp_words.size() != 0) else begin
        $display("Fail at %0t: output word %h with none expected", $time, out_data);
        errors++;
      end
      if (exp_words.size() != 0) begin
        w = exp_words.pop_front();
        l = exp_last.pop_front();
        assert (out_data === w) else begin
          $display("Fail at %0t: word %h, expected %h", $time, out_data, w);
          errors++;
        end
        assert (out_last === l) else begin
          $display("Fail at %0t: out_last %b, expected %b", $time, out_last, l);
          errors++;
        end
      end
      words_seen++;
      if (out_last) begin
        frames_seen++;
      end
    end
  end

  always @(posedge WR_CLK) begin
    case (ready_mode)
      2'd0: begin
        out_ready <= 1'b0;
        ready_idx <= 0;
      end
      2'd1: begin
        out_ready <= 1'b1;
        ready_idx <= 0;
      end
      default: begin
        out_ready <= ready_pat[ready_idx];
        ready_idx <= (ready_idx + 1) % PAT_LEN;
      end
    endcase
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $finish;
  endtask

  task automatic send_beat(input stream_pkg::in_beat_t b);
    int waited;
    waited = 0;
    in_valid <= 1'b1;
    in_beat <= b;
    @(posedge WR_CLK);
    while (!in_ready) begin
      waited++;
      if (waited > 500) begin
        abort_run("timeout: an input beat was never accepted");
      end
      @(posedge WR_CLK);
    end
  endtask

  task automatic idle_cycles(input int n);
    in_valid <= 1'b0;
    repeat (n) @(posedge WR_CLK);
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    in_valid <= 1'b0;
    @(posedge WR_CLK);
    while (model_open || exp_words.size() != 0) begin
      waited++;
      if (waited > limit) begin
        abort_run("timeout: expected frames did not come out");
      end
      @(posedge WR_CLK);
    end
    @(posedge WR_CLK);
  endtask

  task automatic check_count(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
      tests_ok++;
    end else begin
      $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_before);
      tests_bad++;
    end
  endtask

  task automatic fill_ready_pattern();
    int k;
    for (k = 0; k < PAT_LEN; k++) begin
      // two long stalls to back the FIFOs up
      if (k < 150 || (k >= 500 && k < 620)) begin
        ready_pat[k] = 1'b0;
      end else begin
        ready_pat[k] = (($random(seed) & 3) != 0);
      end
    end
  endtask

  initial begin
    int i;
    int r;
    int waited;
    int err_mark;
    int w0;
    int f0;
    int fe0;
    seed = 32'h10e2_e96d;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    words_seen = 0;
    frames_seen = 0;
    frames_expected = 0;
    idle_count = 0;
    model_open = 1'b0;
    stall_seen = 1'b0;
    WR_CLK = 1'b0;
    WR_RESET = 1'b1;
    hold_len = HOLD;
    in_valid = 1'b0;
    in_beat = '0;
    out_ready = 1'b0;
    ready_mode = 2'd0;

    // reset behavior
    err_mark = errors;
    for (i = 0; i < 16; i++) begin
      @(posedge WR_CLK);
      if (i > 0) begin
        assert (!in_ready && !out_valid) else begin
          $display("Fail at %0t: in_ready or out_valid high in reset", $time);
          errors++;
        end
      end
    end
    WR_RESET <= 1'b0;
    ready_mode <= 2'd1;
    waited = 0;
    @(posedge WR_CLK);
    while (!in_ready) begin
      waited++;
      if (waited > 20) begin
        abort_run("timeout: in_ready did not rise after reset");
      end
      @(posedge WR_CLK);
    end
    report_test(1, "reset", err_mark);

    // one short frame
    err_mark = errors;
    w0 = words_seen;
    f0 = frames_seen;
    for (i = 0; i < 3; i++) begin
      send_beat(make_beat());
    end
    wait_drain(300);
    check_count("words out", words_seen - w0, 8);
    check_count("frames out", frames_seen - f0, 1);
    report_test(2, "single frame", err_mark);

    // gaps inside and past the hold window
    err_mark = errors;
    w0 = words_seen;
    f0 = frames_seen;
    send_beat(make_beat());
    idle_cycles(HOLD);
    send_beat(make_beat());
    idle_cycles(HOLD);
    send_beat(make_beat());
    idle_cycles(HOLD + 2);
    send_beat(make_beat());
    send_beat(make_beat());
    wait_drain(300);
    check_count("words out", words_seen - w0, 14);
    check_count("frames out", frames_seen - f0, 2);
    report_test(3, "hold window", err_mark);

    // length limit with output held off
    err_mark = errors;
    w0 = words_seen;
    f0 = frames_seen;
    ready_mode <= 2'd0;
    for (i = 0; i < 20; i++) begin
      send_beat(make_beat());
    end
    ready_mode <= 2'd1;
    wait_drain(500);
    check_count("words out", words_seen - w0, 44);
    check_count("frames out", frames_seen - f0, 2);
    report_test(4, "length split", err_mark);

    // random gaps and random back-pressure
    err_mark = errors;
    w0 = words_seen;
    f0 = frames_seen;
    fe0 = frames_expected;
    fill_ready_pattern();
    stall_seen = 1'b0;
    ready_mode <= 2'd2;
    for (i = 0; i < 200; i++) begin
      send_beat(make_beat());
      r = $random(seed) & 15;
      if (r > 8) begin
        idle_cycles(r - 8);
      end
    end
    wait_drain(5000);
    ready_mode <= 2'd1;
    check_count("frames out", frames_seen - f0, frames_expected - fe0);
    check_count("words out", words_seen - w0, 400 + 2 * (frames_expected - fe0));
    check_count("input stall seen", int'(stall_seen), 1);
    report_test(5, "random traffic", err_mark);

    err_mark = errors;
    check_count("property failures", int'(dut0.props0.fail_count), 0);
    report_test(6, "bound properties", err_mark);

    $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog/adc_frame_macros.svh
`ifndef ADC_FRAME_MACROS_SVH
`define ADC_FRAME_MACROS_SVH

// beat and word widths
`define SAMPLE_WIDTH 128
`define WORD_WIDTH 64
`define STAMP_WIDTH 48
`define ADC_WIDTH 12

// trigger stretch counter
`define HOLD_WIDTH 5

// frame limit
`define MAX_FRAME_BEATS 16

// data fifo holds at least one full frame
`define DATA_FIFO_DEPTH 32
`define INFO_FIFO_DEPTH 4

// frame markers
`define HEADER_ID 8'hFF
`define FOOTER_ID 8'h0F

`endif

// File: verilog/adc_frame_top.sv
`timescale 1ns/1ps
`include "adc_frame_macros.svh"

module adc_frame_top #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                    WR_CLK,
  input  logic                    WR_RESET,
  input  logic [`HOLD_WIDTH-1:0]  hold_len,
  input  logic                    in_valid,
  input  stream_pkg::in_beat_t    in_beat,
  output logic                    in_ready,
  output logic                    out_valid,
  output logic [`WORD_WIDTH-1:0]  out_data,
  output logic                    out_last,
  input  logic                    out_ready
);

  localparam int INFO_WIDTH = $bits(frame_format_pkg::info_t);

  logic                       dec_valid;
  logic                       dec_ready;
  stream_pkg::dec_beat_t      dec_beat;
  stream_pkg::close_t         close_valid;
  logic                       data_wr_valid;
  logic                       data_wr_ready;
  logic [`SAMPLE_WIDTH-1:0]   data_wr;
  logic                       info_wr_valid;
  logic                       info_wr_ready;
  frame_format_pkg::info_t    info_wr;
  logic                       data_rd_valid;
  logic                       data_rd_ready;
  logic [`SAMPLE_WIDTH-1:0]   data_rd;
  logic                       info_rd_valid;
  logic                       info_rd_ready;
  frame_format_pkg::info_t    info_rd;

  beat_decoder dec0 (
    .WR_CLK      (WR_CLK),
    .WR_RESET    (WR_RESET),
    .hold_len    (hold_len),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .in_ready    (in_ready),
    .dec_valid   (dec_valid),
    .dec_beat    (dec_beat),
    .dec_ready   (dec_ready),
    .close_valid (close_valid)
  );

  frame_assembler #(
    .CHANNEL_ID (CHANNEL_ID)
  ) asm0 (
    .WR_CLK        (WR_CLK),
    .WR_RESET      (WR_RESET),
    .dec_valid     (dec_valid),
    .dec_beat      (dec_beat),
    .dec_ready     (dec_ready),
    .close_valid   (close_valid),
    .data_wr_valid (data_wr_valid),
    .data_wr       (data_wr),
    .data_wr_ready (data_wr_ready),
    .info_wr_valid (info_wr_valid),
    .info_wr       (info_wr),
    .info_wr_ready (info_wr_ready)
  );

  frame_fifo #(
    .WIDTH (`SAMPLE_WIDTH),
    .DEPTH (`DATA_FIFO_DEPTH)
  ) data_fifo0 (
    .WR_CLK   (WR_CLK),
    .WR_RESET (WR_RESET),
    .wr_valid (data_wr_valid),
    .wr_data  (data_wr),
    .wr_ready (data_wr_ready),
    .rd_valid (data_rd_valid),
    .rd_data  (data_rd),
    .rd_ready (data_rd_ready)
  );

  frame_fifo #(
    .WIDTH (INFO_WIDTH),
    .DEPTH (`INFO_FIFO_DEPTH)
  ) info_fifo0 (
    .WR_CLK   (WR_CLK),
    .WR_RESET (WR_RESET),
    .wr_valid (info_wr_valid),
    .wr_data  (info_wr),
    .wr_ready (info_wr_ready),
    .rd_valid (info_rd_valid),
    .rd_data  (info_rd),
    .rd_ready (info_rd_ready)
  );

  frame_serializer ser0 (
    .WR_CLK     (WR_CLK),
    .WR_RESET   (WR_RESET),
    .info_valid (info_rd_valid),
    .info       (info_rd),
    .info_ready (info_rd_ready),
    .data_valid (data_rd_valid),
    .data       (data_rd),
    .data_ready (data_rd_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last),
    .out_ready  (out_ready)
  );

endmodule

// File: verilog/beat_decoder.sv
`timescale 1ns/1ps
`include "adc_frame_macros.svh"

module beat_decoder (
  input  logic                     WR_CLK,
  input  logic                     WR_RESET,
  input  logic [`HOLD_WIDTH-1:0]   hold_len,
  input  logic                     in_valid,
  input  stream_pkg::in_beat_t     in_beat,
  output logic                     in_ready,
  output logic                     dec_valid,
  output stream_pkg::dec_beat_t    dec_beat,
  input  logic                     dec_ready,
  output stream_pkg::close_t       close_valid
);

  localparam int CNT_W = $clog2(`MAX_FRAME_BEATS) + 1;

  logic                   run_q;
  logic [`HOLD_WIDTH-1:0] hold_q;
  logic                   open_q;
  logic [CNT_W-1:0]       count_q;
  logic [CNT_W-1:0]       count_next;
  logic [`HOLD_WIDTH:0]   gap_q;
  logic                   in_fire;
  logic                   due;
  logic                   starts;
  logic                   ends;

  assign in_ready = run_q & (~dec_valid | dec_ready);
  assign in_fire = in_valid & in_ready;

  // gap past hold_len, or at hold_len with no beat now
  assign due = open_q & ((gap_q > {1'b0, hold_q}) | ((gap_q == {1'b0, hold_q}) & ~in_fire));

  // a beat of this frame still in the stage goes first
  assign close_valid = due & (~dec_valid | dec_ready);

  assign starts = ~open_q | due;
  assign count_next = starts ? CNT_W'(1) : count_q + 1'b1;
  assign ends = (count_next == CNT_W'(`MAX_FRAME_BEATS));

  always_ff @(posedge WR_CLK) begin
    if (WR_RESET) begin
      hold_q <= hold_len;
      run_q <= 1'b0;
      open_q <= 1'b0;
      count_q <= '0;
      gap_q <= '0;
      dec_valid <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (in_fire) begin
        open_q <= ~ends;
        count_q <= count_next;
        gap_q <= '0;
      end else begin
        if (close_valid) begin
          open_q <= 1'b0;
        end
        if (open_q && gap_q != '1) begin
          gap_q <= gap_q + 1'b1;
        end
      end
      if (in_fire) begin
        dec_valid <= 1'b1;
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
    end
  end

  // one-entry stage
  always_ff @(posedge WR_CLK) begin
    if (in_fire) begin
      dec_beat.beat <= in_beat;
      dec_beat.frame_open <= starts;
      dec_beat.frame_close <= ends;
    end
  end

endmodule

// File: verilog/frame_assembler.sv
`timescale 1ns/1ps
`include "adc_frame_macros.svh"

module frame_assembler #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                        WR_CLK,
  input  logic                        WR_RESET,
  input  logic                        dec_valid,
  input  stream_pkg::dec_beat_t       dec_beat,
  output logic                        dec_ready,
  input  stream_pkg::close_t          close_valid,
  output logic                        data_wr_valid,
  output logic [`SAMPLE_WIDTH-1:0]    data_wr,
  input  logic                        data_wr_ready,
  output logic                        info_wr_valid,
  output frame_format_pkg::info_t     info_wr,
  input  logic                        info_wr_ready
);

  localparam int CNT_W = $clog2(`MAX_FRAME_BEATS) + 1;

  logic                       dec_fire;
  logic                       close_now;
  logic [CNT_W-1:0]           count_q;
  logic [CNT_W-1:0]           count_next;
  logic [`STAMP_WIDTH/2-1:0]  stamp_lo_q;
  logic [`STAMP_WIDTH/2-1:0]  stamp_lo_next;
  frame_format_pkg::footer_t  footer_q;
  frame_format_pkg::footer_t  footer_next;
  frame_format_pkg::header_t  header_next;

  // both write stages must have room
  assign dec_ready = (~data_wr_valid | data_wr_ready) & (~info_wr_valid | info_wr_ready);
  assign dec_fire = dec_valid & dec_ready;
  assign close_now = close_valid | (dec_fire & dec_beat.frame_close);

  // running frame fields including the beat taken this cycle
  always_comb begin
    count_next = count_q;
    stamp_lo_next = stamp_lo_q;
    footer_next = footer_q;
    if (dec_fire) begin
      if (dec_beat.frame_open) begin
        count_next = CNT_W'(1);
        stamp_lo_next = dec_beat.beat.stamp[`STAMP_WIDTH/2-1:0];
      end else begin
        count_next = count_q + 1'b1;
      end
      // last beat wins
      footer_next.base_fill = '1;
      footer_next.baseline = dec_beat.beat.baseline;
      footer_next.thr_fill = '1;
      footer_next.threshold = dec_beat.beat.threshold;
      footer_next.stamp_hi = dec_beat.beat.stamp[`STAMP_WIDTH-1 -: `STAMP_WIDTH/2];
      footer_next.id = `FOOTER_ID;
    end
  end

  always_comb begin
    header_next.id = `HEADER_ID;
    header_next.channel = 4'(CHANNEL_ID);
    header_next.stamp_lo = stamp_lo_next;
    header_next.pad = '0;
    // two words per beat
    header_next.length = 16'({count_next, 1'b0});
  end

  always_ff @(posedge WR_CLK) begin
    if (WR_RESET) begin
      count_q <= '0;
      data_wr_valid <= 1'b0;
      info_wr_valid <= 1'b0;
    end else begin
      if (dec_fire) begin
        count_q <= count_next;
      end
      if (dec_fire) begin
        data_wr_valid <= 1'b1;
      end else if (data_wr_ready) begin
        data_wr_valid <= 1'b0;
      end
      if (close_now) begin
        info_wr_valid <= 1'b1;
      end else if (info_wr_ready) begin
        info_wr_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge WR_CLK) begin
    if (dec_fire) begin
      stamp_lo_q <= stamp_lo_next;
      footer_q <= footer_next;
      data_wr <= dec_beat.beat.sample;
    end
    if (close_now) begin
      info_wr.header <= header_next;
      info_wr.footer <= footer_next;
    end
  end

endmodule

// File: verilog/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             WR_CLK,
  input  logic             WR_RESET,
  input  logic             wr_valid,
  input  logic [WIDTH-1:0] wr_data,
  output logic             wr_ready,
  output logic             rd_valid,
  output logic [WIDTH-1:0] rd_data,
  input  logic             rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_ready = (count != CNT_W'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data = mem[rd_ptr];
  assign wr_fire = wr_valid & wr_ready;
  assign rd_fire = rd_valid & rd_ready;

  always_ff @(posedge WR_CLK) begin
    if (WR_RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge WR_CLK) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// File: verilog/frame_format_pkg.sv
`include "adc_frame_macros.svh"

package frame_format_pkg;

  // first word of a frame
  typedef struct packed {
    logic [7:0]                  id;
    logic [3:0]                  channel;
    logic [`STAMP_WIDTH/2-1:0]   stamp_lo;
    logic [11:0]                 pad;
    logic [15:0]                 length;
  } header_t;

  // last word with all-ones fills
  typedef struct packed {
    logic [15-`ADC_WIDTH:0]      base_fill;
    logic [`ADC_WIDTH-1:0]       baseline;
    logic [14-`ADC_WIDTH:0]      thr_fill;
    logic [`ADC_WIDTH:0]         threshold;
    logic [`STAMP_WIDTH/2-1:0]   stamp_hi;
    logic [7:0]                  id;
  } footer_t;

  // one output word seen as either marker
  typedef union packed {
    header_t header;
    footer_t footer;
  } frame_word_u;

  // one entry per closed frame
  typedef struct packed {
    footer_t footer;
    header_t header;
  } info_t;

endpackage

// File: verilog/frame_serializer.sv
`timescale 1ns/1ps
`include "adc_frame_macros.svh"

module frame_serializer (
  input  logic                      WR_CLK,
  input  logic                      WR_RESET,
  input  logic                      info_valid,
  input  frame_format_pkg::info_t   info,
  output logic                      info_ready,
  input  logic                      data_valid,
  input  logic [`SAMPLE_WIDTH-1:0]  data,
  output logic                      data_ready,
  output logic                      out_valid,
  output logic [`WORD_WIDTH-1:0]    out_data,
  output logic                      out_last,
  input  logic                      out_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HEADER,
    S_UPPER,
    S_LOWER,
    S_FOOTER
  } state_t;

  state_t                        state_q;
  logic [15:0]                   words_q;
  logic                          out_fire;
  frame_format_pkg::frame_word_u head_word;

  assign head_word = info.header;
  assign out_fire = out_valid & out_ready;
  assign out_last = (state_q == S_FOOTER);

  // info stays at the FIFO head until its footer leaves
  assign info_ready = out_fire & (state_q == S_FOOTER);
  assign data_ready = out_fire & (state_q == S_LOWER);

  // FIFO heads only move on a pop, so the word holds under stall
  always_comb begin
    case (state_q)
      S_HEADER: begin
        out_valid = info_valid;
        out_data = head_word;
      end
      S_UPPER: begin
        out_valid = data_valid;
        out_data = data[`SAMPLE_WIDTH-1 -: `WORD_WIDTH];
      end
      S_LOWER: begin
        out_valid = data_valid;
        out_data = data[`WORD_WIDTH-1:0];
      end
      S_FOOTER: begin
        out_valid = info_valid;
        out_data = info.footer;
      end
      default: begin
        out_valid = 1'b0;
        out_data = head_word;
      end
    endcase
  end

  always_ff @(posedge WR_CLK) begin
    if (WR_RESET) begin
      state_q <= S_IDLE;
      words_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (info_valid) begin
            state_q <= S_HEADER;
          end
        end
        S_HEADER: begin
          if (out_fire) begin
            words_q <= head_word.header.length;
            state_q <= (head_word.header.length == '0) ? S_FOOTER : S_UPPER;
          end
        end
        S_UPPER: begin
          if (out_fire) begin
            words_q <= words_q - 1'b1;
            state_q <= S_LOWER;
          end
        end
        S_LOWER: begin
          if (out_fire) begin
            words_q <= words_q - 1'b1;
            state_q <= (words_q == 16'd1) ? S_FOOTER : S_UPPER;
          end
        end
        S_FOOTER: begin
          if (out_fire) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/stream_pkg.sv
`include "adc_frame_macros.svh"

package stream_pkg;

  // raw input beat of 201 bits
  typedef struct packed {
    logic [`SAMPLE_WIDTH-1:0] sample;
    logic [`STAMP_WIDTH-1:0]  stamp;
    logic [`ADC_WIDTH-1:0]    baseline;
    logic [`ADC_WIDTH:0]      threshold;
  } in_beat_t;

  // beat with frame boundary marks
  typedef struct packed {
    in_beat_t beat;
    logic     frame_open;
    logic     frame_close;
  } dec_beat_t;

  // timeout close with no beat attached
  typedef logic close_t;

endpackage
